// File: verilog.f
logic/armPkg.sv
logic/hazardUnit.sv
logic/regFile.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/retireStage.sv
logic/armCore.sv
sim/clockGen.sv
sim/armCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# Compile and run the armCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module armCoreTb \
  -f verilog.f -o armCoreSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

simOutput="$(./obj_dir/armCoreSim)"
simStatus=$?
printf '%s\n' "$simOutput"
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with an error status"
  exit 1
fi

if grep -q "Result: PASSED" <<< "$simOutput"; then
  exit 0
fi
exit 1

// File: sim/armCoreTb.sv
`timescale 1ns/100ps

module armCoreTb;

  import armPkg::*;

  localparam int resetCycles = 8;
  localparam int maxEntries = 32;

  logic    clk;
  logic    rstN;
  wordT    instrF;
  wordT    pcF;
  logic    regWriteW;
  regAddrT wa3W;
  wordT    resultW;
  flagsT   flags;

  // Program table with expected writeback per entry
  string   progName [maxEntries];
  wordT    progInstr [maxEntries];
  regAddrT progRd [maxEntries];
  wordT    progValue [maxEntries];
  flagsT   progFlags [maxEntries];
  int      progLen;

  // Reference state used to fill in expected values
  wordT    modelRegs [16];
  flagsT   modelFlags;
  integer  seed;
  int      cycleCount;

  clockGen #(.periodNs(100)) clkGen (.clk(clk));

  armCore #(.resetPc(32'h0000_0000)) dut (
    .clk(clk), .rstN(rstN), .instrF(instrF), .pcF(pcF), .regWriteW(regWriteW),
    .wa3W(wa3W), .resultW(resultW), .flags(flags)
  );

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic reportMismatch(input string name, input wordT expected, input wordT actual);
    failRun($sformatf("MISMATCH %s: expected %h, actual %h", name, expected, actual));
  endtask

  function automatic wordT immInstr(input aluOpT op, input logic s, input regAddrT rn,
                                    input regAddrT rd, input logic [3:0] rot,
                                    input logic [7:0] imm8);
    return {4'hE, 2'b00, 1'b1, op, s, rn, rd, rot, imm8};
  endfunction

  function automatic wordT regInstr(input aluOpT op, input logic s, input regAddrT rn,
                                    input regAddrT rd, input regAddrT rm);
    return {4'hE, 2'b00, 1'b0, op, s, rn, rd, 8'h00, rm};
  endfunction

  // One bit at a time
  function automatic wordT rotateRight(input logic [7:0] byteVal, input int amount);
    wordT value;
    value = {24'b0, byteVal};
    for (int i = 0; i < amount; i++) begin
      value = {value[0], value[31:1]};
    end
    return value;
  endfunction

  function automatic wordT readModel(input regAddrT r, input int index);
    return (r == 4'd15) ? wordT'(4 * index + 8) : modelRegs[r];
  endfunction

  // Apply the instruction to the reference state and record the entry
  task automatic addEntry(input string name, input wordT instr);
    aluOpT       op;
    wordT        a;
    wordT        b;
    wordT        res;
    logic [32:0] wide;
    logic        arith;
    logic        cNew;
    logic        vNew;
    op = aluOpT'(instr[24:21]);
    a = (op == aluMov) ? '0 : readModel(instr[19:16], progLen);
    b = instr[25] ? rotateRight(instr[7:0], 2 * instr[11:8]) : readModel(instr[3:0], progLen);
    arith = (op == aluAdd) || (op == aluSub);
    cNew = 1'b0;
    vNew = 1'b0;
    case (op)
      aluAdd: begin
        wide = {1'b0, a} + {1'b0, b};
        res = wide[31:0];
        cNew = wide[32];
        vNew = (a[31] == b[31]) && (res[31] != a[31]);
      end
      aluSub: begin
        res = a - b;
        cNew = (a >= b);
        vNew = (a[31] != b[31]) && (res[31] != a[31]);
      end
      aluAnd:  res = a & b;
      aluEor:  res = a ^ b;
      aluOrr:  res = a | b;
      default: res = b;
    endcase
    if (instr[20]) begin
      modelFlags.n = res[31];
      modelFlags.z = (res == '0);
      if (arith) begin
        modelFlags.c = cNew;
        modelFlags.v = vNew;
      end
    end
    modelRegs[instr[15:12]] = res;
    progName[progLen] = name;
    progInstr[progLen] = instr;
    progRd[progLen] = instr[15:12];
    progValue[progLen] = res;
    progFlags[progLen] = modelFlags;
    progLen++;
  endtask

  task automatic buildProgram();
    wordT rnd;
    progLen = 0;
    modelFlags = '0;
    rnd = $random(seed);
    addEntry("mov imm rot 0", immInstr(aluMov, 1'b0, 4'd0, 4'd1, 4'd0, rnd[7:0]));
    rnd = $random(seed);
    addEntry("mov imm rot 1", immInstr(aluMov, 1'b0, 4'd0, 4'd2, 4'd1, rnd[7:0]));
    rnd = $random(seed);
    addEntry("mov imm rot 15", immInstr(aluMov, 1'b0, 4'd0, 4'd3, 4'd15, rnd[7:0]));
    // Distances of one, two and three between producer and consumer
    addEntry("add fwd wb and bypass", regInstr(aluAdd, 1'b0, 4'd1, 4'd4, 4'd2));
    addEntry("sub fwd mem and wb", regInstr(aluSub, 1'b0, 4'd4, 4'd5, 4'd3));
    addEntry("eor bypass and mem", regInstr(aluEor, 1'b0, 4'd3, 4'd6, 4'd5));
    addEntry("and reg", regInstr(aluAnd, 1'b0, 4'd6, 4'd7, 4'd4));
    addEntry("orr reg", regInstr(aluOrr, 1'b0, 4'd7, 4'd8, 4'd5));
    // Flag updates
    addEntry("movs zero", immInstr(aluMov, 1'b1, 4'd0, 4'd9, 4'd0, 8'h00));
    addEntry("mov sign bit", immInstr(aluMov, 1'b0, 4'd0, 4'd10, 4'd1, 8'h02));
    addEntry("adds carry overflow", regInstr(aluAdd, 1'b1, 4'd10, 4'd11, 4'd10));
    addEntry("movs negative keeps cv", immInstr(aluMov, 1'b1, 4'd0, 4'd9, 4'd1, 8'h02));
    addEntry("mov one", immInstr(aluMov, 1'b0, 4'd0, 4'd12, 4'd0, 8'h01));
    addEntry("subs equal", regInstr(aluSub, 1'b1, 4'd12, 4'd13, 4'd12));
    addEntry("subs overflow", regInstr(aluSub, 1'b1, 4'd9, 4'd13, 4'd12));
    // C and V are both set here, so the logical ops must keep them
    addEntry("ands zero", regInstr(aluAnd, 1'b1, 4'd10, 4'd0, 4'd12));
    addEntry("eors negative", regInstr(aluEor, 1'b1, 4'd10, 4'd0, 4'd12));
    addEntry("subs borrow", regInstr(aluSub, 1'b1, 4'd12, 4'd14, 4'd10));
    addEntry("adds clears", regInstr(aluAdd, 1'b1, 4'd12, 4'd14, 4'd12));
    // R15 operands
    addEntry("add r15 imm", immInstr(aluAdd, 1'b0, 4'd15, 4'd1, 4'd0, 8'h00));
    addEntry("mov r15 reg", regInstr(aluMov, 1'b0, 4'd0, 4'd2, 4'd15));
    addEntry("orrs r15", regInstr(aluOrr, 1'b1, 4'd15, 4'd3, 4'd1));
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      addEntry($sformatf("adds random imm %0d", i),
               immInstr(aluAdd, 1'b1, regAddrT'(4 + i), regAddrT'(5 + i), rnd[11:8], rnd[7:0]));
    end
  endtask

  function automatic wordT fetchWord(input wordT addr);
    int index;
    index = int'(addr >> 2);
    if (index < progLen) begin
      return progInstr[index];
    end
    return nopInstr;
  endfunction

  task automatic checkCycle(input int cyc);
    int k;
    assert (pcF == wordT'(4 * cyc))
      else reportMismatch($sformatf("pcF cycle %0d", cyc), wordT'(4 * cyc), pcF);
    if (cyc < 4) begin
      assert (!regWriteW) else failRun("regWriteW went high while the pipeline was filling");
      assert (flags == '0) else reportMismatch("flags after reset", '0, {28'b0, flags});
    end else begin
      k = cyc - 4;
      assert (regWriteW) else failRun($sformatf("No writeback for entry %s", progName[k]));
      assert (wa3W == progRd[k])
        else reportMismatch({progName[k], " rd"}, {28'b0, progRd[k]}, {28'b0, wa3W});
      assert (resultW == progValue[k])
        else reportMismatch({progName[k], " value"}, progValue[k], resultW);
      assert (flags == progFlags[k])
        else reportMismatch({progName[k], " flags"}, {28'b0, progFlags[k]}, {28'b0, flags});
    end
  endtask

  // Run limit covers reset, the table and the pipeline depth, with margin
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > resetCycles + progLen + 4 + 20) begin
      failRun("Timeout, the run went past its cycle limit");
    end
  end

  initial begin
    seed = 32'h71d1bffb;
    cycleCount = 0;
    rstN = 1'b0;
    instrF = nopInstr;
    buildProgram();
    repeat (resetCycles) @(posedge clk);
    #1;
    rstN = 1'b1;
    for (int cyc = 0; cyc < progLen + 4; cyc++) begin
      instrF = fetchWord(pcF);
      // Sample mid-cycle
      #49;
      checkCycle(cyc);
      @(posedge clk);
      #1;
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: sim/clockGen.sv
`timescale 1ns/100ps

module clockGen #(
  parameter int periodNs = 100
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(periodNs / 2) clk = ~clk;
    end
  end

endmodule

// File: logic/armCore.sv
`timescale 1ns/100ps

module armCore #(
  parameter armPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            rstN,
  input  armPkg::wordT    instrF,
  output armPkg::wordT    pcF,
  output logic            regWriteW,
  output armPkg::regAddrT wa3W,
  output armPkg::wordT    resultW,
  output armPkg::flagsT   flags
);

  import armPkg::*;

  wordT     pcPlus8;
  wordT     rd1;
  wordT     rd2;
  regAddrT  ra1;
  regAddrT  ra2;
  decToExeT decPayload;
  exeToRetT exePayload;
  regAddrT  ra1E;
  regAddrT  ra2E;
  fwdSelT   fwdA;
  fwdSelT   fwdB;
  wordT     aluOutM;
  regAddrT  wa3M;
  logic     regWriteM;

  decodeStage #(.resetPc(resetPc)) decode (
    .clk(clk), .rstN(rstN), .instrF(instrF), .rd1(rd1), .rd2(rd2),
    .pcF(pcF), .pcPlus8(pcPlus8), .ra1(ra1), .ra2(ra2), .decPayload(decPayload)
  );

  // R15 reads as the decode instruction's address plus 8
  regFile rf (
    .clk(clk), .we(regWriteW), .ra1(ra1), .ra2(ra2), .wa3(wa3W), .wd3(resultW),
    .r15(pcPlus8), .rd1(rd1), .rd2(rd2)
  );

  executeStage execute (
    .clk(clk), .rstN(rstN), .decPayload(decPayload), .fwdA(fwdA), .fwdB(fwdB),
    .aluOutM(aluOutM), .resultW(resultW), .ra1E(ra1E), .ra2E(ra2E),
    .exePayload(exePayload)
  );

  hazardUnit hazard (
    .ra1E(ra1E), .ra2E(ra2E), .wa3M(wa3M), .regWriteM(regWriteM),
    .wa3W(wa3W), .regWriteW(regWriteW), .fwdA(fwdA), .fwdB(fwdB)
  );

  retireStage retire (
    .clk(clk), .rstN(rstN), .exePayload(exePayload), .aluOutM(aluOutM),
    .wa3M(wa3M), .regWriteM(regWriteM), .regWriteW(regWriteW), .wa3W(wa3W),
    .resultW(resultW), .flags(flags)
  );

endmodule

// File: logic/retireStage.sv
`timescale 1ns/100ps

module retireStage (
  input  logic             clk,
  input  logic             rstN,
  input  armPkg::exeToRetT exePayload,
  output armPkg::wordT     aluOutM,
  output armPkg::regAddrT  wa3M,
  output logic             regWriteM,
  output logic             regWriteW,
  output armPkg::regAddrT  wa3W,
  output armPkg::wordT     resultW,
  output armPkg::flagsT    flags
);

  import armPkg::*;

  exeToRetT memReg;
  exeToRetT wbReg;
  flagsT    flagsReg;

  always_ff @(posedge clk) begin
    memReg <= exePayload;
    wbReg  <= memReg;
    if (!rstN) begin
      memReg.regWrite <= 1'b0;
      memReg.setFlags <= 1'b0;
      wbReg.regWrite  <= 1'b0;
      wbReg.setFlags  <= 1'b0;
    end
  end

  assign aluOutM   = memReg.aluResult;
  assign wa3M      = memReg.wa3;
  assign regWriteM = memReg.regWrite;
  assign regWriteW = wbReg.regWrite;
  assign wa3W      = wbReg.wa3;
  assign resultW   = wbReg.aluResult;

  // Committed flags merged with the writeback instruction's update
  always_comb begin
    flags = flagsReg;
    if (wbReg.setFlags) begin
      flags.n = wbReg.flagsNext.n;
      flags.z = wbReg.flagsNext.z;
      if (!wbReg.keepCv) begin
        flags.c = wbReg.flagsNext.c;
        flags.v = wbReg.flagsNext.v;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flagsReg <= '0;
    end else begin
      flagsReg <= flags;
    end
  end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/100ps

module executeStage (
  input  logic             clk,
  input  logic             rstN,
  input  armPkg::decToExeT decPayload,
  input  armPkg::fwdSelT   fwdA,
  input  armPkg::fwdSelT   fwdB,
  input  armPkg::wordT     aluOutM,
  input  armPkg::wordT     resultW,
  output armPkg::regAddrT  ra1E,
  output armPkg::regAddrT  ra2E,
  output armPkg::exeToRetT exePayload
);

  import armPkg::*;

  decToExeT exeReg;
  wordT     srcA;
  wordT     regB;
  wordT     srcB;
  wordT     bIn;
  wordT     sum;
  logic     carry;
  logic     isSub;
  logic     isArith;
  logic     overflow;
  wordT     result;

  // Reset clears the control bits so the slot holds a bubble
  always_ff @(posedge clk) begin
    exeReg <= decPayload;
    if (!rstN) begin
      exeReg.regWrite <= 1'b0;
      exeReg.setFlags <= 1'b0;
    end
  end

  function automatic wordT pickOperand(input fwdSelT sel, input wordT regVal,
                                       input wordT memVal, input wordT wbVal);
    case (sel)
      fwdMem:  return memVal;
      fwdWb:   return wbVal;
      default: return regVal;
    endcase
  endfunction

  assign srcA = exeReg.usesRn ? pickOperand(fwdA, exeReg.rd1, aluOutM, resultW) : '0;
  assign regB = pickOperand(fwdB, exeReg.rd2, aluOutM, resultW);
  assign srcB = exeReg.immSel ? exeReg.imm : regB;

  // Shared adder where SUB adds the inverted operand plus one
  assign isSub = (exeReg.aluOp == aluSub);
  assign isArith = isSub || (exeReg.aluOp == aluAdd);
  assign bIn = isSub ? ~srcB : srcB;
  assign {carry, sum} = {1'b0, srcA} + {1'b0, bIn} + {32'b0, isSub};
  assign overflow = (srcA[31] == bIn[31]) && (sum[31] != srcA[31]);

  always_comb begin
    case (exeReg.aluOp)
      aluAnd:         result = srcA & srcB;
      aluEor:         result = srcA ^ srcB;
      aluSub, aluAdd: result = sum;
      // ORR and also MOV since its srcA is zero
      default:        result = srcA | srcB;
    endcase
  end

  assign ra1E = exeReg.ra1;
  assign ra2E = exeReg.ra2;

  always_comb begin
    exePayload.aluResult   = result;
    exePayload.wa3         = exeReg.wa3;
    exePayload.regWrite    = exeReg.regWrite;
    exePayload.setFlags    = exeReg.setFlags;
    exePayload.keepCv      = !isArith;
    exePayload.flagsNext.n = result[31];
    exePayload.flagsNext.z = (result == '0);
    // Candidate C and V are dropped when keepCv is set
    exePayload.flagsNext.c = carry;
    exePayload.flagsNext.v = overflow;
  end

endmodule

// File: logic/decodeStage.sv
`timescale 1ns/100ps

module decodeStage #(
  parameter armPkg::wordT resetPc = 32'h0000_0000
) (
  input  logic               clk,
  input  logic               rstN,
  input  armPkg::wordT       instrF,
  input  armPkg::wordT       rd1,
  input  armPkg::wordT       rd2,
  output armPkg::wordT       pcF,
  output armPkg::wordT       pcPlus8,
  output armPkg::regAddrT    ra1,
  output armPkg::regAddrT    ra2,
  output armPkg::decToExeT   decPayload
);

  import armPkg::*;

  wordT        pcReg;
  wordT        instrD;
  logic        opSupported;
  aluOpT       aluOpD;
  logic [63:0] immDouble;
  wordT        rotImm;

  // Fetch address, no stalls so it always advances
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pcReg <= resetPc;
    end else begin
      pcReg <= pcReg + 32'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      instrD <= nopInstr;
    end else begin
      instrD <= instrF;
    end
  end

  assign pcF = pcReg;
  // PC has moved one word past the decode instruction already
  assign pcPlus8 = pcReg + 32'd4;

  assign aluOpD = aluOpT'(instrD[24:21]);

  always_comb begin
    opSupported = 1'b0;
    if (instrD[27:26] == 2'b00) begin
      case (instrD[24:21])
        aluAnd, aluEor, aluSub, aluAdd, aluOrr, aluMov: opSupported = 1'b1;
        default: opSupported = 1'b0;
      endcase
    end
  end

  // Rotate right by twice the rotate field
  assign immDouble = {24'b0, instrD[7:0], 24'b0, instrD[7:0]};
  assign rotImm = wordT'(immDouble >> {instrD[11:8], 1'b0});

  // Rn and Rm
  assign ra1 = instrD[19:16];
  assign ra2 = instrD[3:0];

  always_comb begin
    decPayload.rd1      = rd1;
    decPayload.rd2      = rd2;
    decPayload.imm      = rotImm;
    decPayload.ra1      = ra1;
    decPayload.ra2      = ra2;
    decPayload.wa3      = instrD[15:12];
    decPayload.aluOp    = aluOpD;
    decPayload.immSel   = instrD[25];
    decPayload.setFlags = instrD[20] & opSupported;
    decPayload.usesRn   = (aluOpD != aluMov);
    decPayload.regWrite = opSupported;
  end

endmodule

// File: logic/regFile.sv
`timescale 1ns/100ps

module regFile (
  input  logic            clk,
  input  logic            we,
  input  armPkg::regAddrT ra1,
  input  armPkg::regAddrT ra2,
  input  armPkg::regAddrT wa3,
  input  armPkg::wordT    wd3,
  input  armPkg::wordT    r15,
  output armPkg::wordT    rd1,
  output armPkg::wordT    rd2
);

  import armPkg::*;

  wordT regs [0:14];

  always_ff @(posedge clk) begin
    if (we && wa3 != 4'd15) begin
      regs[wa3] <= wd3;
    end
  end

  // Write data bypasses straight to the read ports
  function automatic wordT readPort(input regAddrT ra);
    if (ra == 4'd15) begin
      return r15;
    end else if (we && wa3 == ra) begin
      return wd3;
    end
    return regs[ra];
  endfunction

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule

// File: logic/hazardUnit.sv
`timescale 1ns/100ps

module hazardUnit (
  input  armPkg::regAddrT ra1E,
  input  armPkg::regAddrT ra2E,
  input  armPkg::regAddrT wa3M,
  input  logic            regWriteM,
  input  armPkg::regAddrT wa3W,
  input  logic            regWriteW,
  output armPkg::fwdSelT  fwdA,
  output armPkg::fwdSelT  fwdB
);

  import armPkg::*;

  // Memory stage holds the younger result, so it wins
  function automatic fwdSelT selectSource(input regAddrT ra);
    if (regWriteM && wa3M == ra) begin
      return fwdMem;
    end else if (regWriteW && wa3W == ra) begin
      return fwdWb;
    end
    return fwdNone;
  endfunction

  always_comb begin
    fwdA = selectSource(ra1E);
    fwdB = selectSource(ra2E);
  end

endmodule

// File: logic/armPkg.sv
package armPkg;

  typedef logic [3:0] regAddrT;
  typedef logic [31:0] wordT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // Encodings match the data-processing opcode field, bits 24 to 21
  typedef enum logic [3:0] {
    aluAnd = 4'b0000,
    aluEor = 4'b0001,
    aluSub = 4'b0010,
    aluAdd = 4'b0100,
    aluOrr = 4'b1100,
    aluMov = 4'b1101
  } aluOpT;

  typedef enum logic [1:0] {
    fwdNone = 2'b00,
    fwdMem  = 2'b01,
    fwdWb   = 2'b10
  } fwdSelT;

  // Decode to execute, 116 bits
  typedef struct packed {
    wordT    rd1;
    wordT    rd2;
    wordT    imm;
    regAddrT ra1;
    regAddrT ra2;
    regAddrT wa3;
    aluOpT   aluOp;
    logic    immSel;
    logic    setFlags;
    logic    usesRn;
    logic    regWrite;
  } decToExeT;

  // Execute to memory and writeback, 43 bits
  typedef struct packed {
    wordT    aluResult;
    regAddrT wa3;
    logic    regWrite;
    logic    setFlags;
    logic    keepCv;
    flagsT   flagsNext;
  } exeToRetT;

  // Architectural NOP hint, its opcode lies outside the supported set
  localparam wordT nopInstr = 32'hE320_F000;

endpackage
